// ==== src/pcie_app_pkg.sv ====
package pcie_app_pkg;

   typedef logic [63:0] qword_t;
   typedef logic [12:0] qword_addr_t;
   typedef logic [23:0] rid_tag_t;
   typedef logic [15:0] pcie_id_t;
   typedef logic [63:0] host_addr_t;
   typedef logic [3:0]  lower_addr_t;
   typedef logic [15:0] count_t;
   typedef logic [7:0]  keep_t;
   typedef logic [3:0]  led_t;

   typedef enum logic [1:0] {
      rx_header,
      rx_address,
      rx_payload
   } rx_state_t;

   typedef enum logic [1:0] {
      tx_idle,
      tx_beat1,
      tx_beat2,
      tx_beat3
   } tx_state_t;

   // fmt and type fields of DW0, bits 30 to 24
   localparam logic [6:0] mrd32 = 7'h00;
   localparam logic [6:0] mrd64 = 7'h20;
   localparam logic [6:0] mwr32 = 7'h40;
   localparam logic [6:0] mwr64 = 7'h60;
   localparam logic [6:0] cpld  = 7'h4a;

   // qword register map
   localparam qword_addr_t reg_scratch     = 13'd0;
   localparam qword_addr_t reg_cpl_count   = 13'd1;
   localparam qword_addr_t reg_write_count = 13'd2;
   localparam qword_addr_t reg_read_count  = 13'd3;
   localparam qword_addr_t reg_dma_write   = 13'd100;
   localparam qword_addr_t reg_dma_read    = 13'd101;

   localparam logic [31:0] bad_addr_marker = 32'hdeadbeef;
   localparam qword_t      write_seed      = 64'h100;
   localparam led_t        led_reset       = 4'h5;

endpackage

// ==== src/pcie_app_if.sv ====
interface rx_req_if;
   logic                       write_valid;
   logic                       read_valid;
   logic                       completion_valid;
   pcie_app_pkg::qword_t       data;
   pcie_app_pkg::qword_addr_t  address;
   pcie_app_pkg::rid_tag_t     rid_tag;

   modport parser (output write_valid, read_valid, completion_valid, data, address, rid_tag);
   modport consumer (input write_valid, read_valid, completion_valid, data, address, rid_tag);
endinterface

interface tx_req_if;
   // completion channel
   logic                       cpl_valid;
   pcie_app_pkg::rid_tag_t     cpl_rid_tag;
   pcie_app_pkg::lower_addr_t  cpl_lower_addr;
   pcie_app_pkg::qword_t       cpl_data;
   logic                       cpl_ready;
   // outgoing memory write
   logic                       wr_valid;
   pcie_app_pkg::host_addr_t   wr_addr;
   pcie_app_pkg::qword_t       wr_data;
   logic                       wr_ready;
   // outgoing memory read
   logic                       rd_valid;
   pcie_app_pkg::host_addr_t   rd_addr;
   logic                       rd_ready;
   // a TLP is still on its way out
   logic                       busy;

   modport requester (output cpl_valid, cpl_rid_tag, cpl_lower_addr, cpl_data,
                      output wr_valid, wr_addr, wr_data, rd_valid, rd_addr,
                      input cpl_ready, wr_ready, rd_ready, busy);
   modport builder (input cpl_valid, cpl_rid_tag, cpl_lower_addr, cpl_data,
                    input wr_valid, wr_addr, wr_data, rd_valid, rd_addr,
                    output cpl_ready, wr_ready, rd_ready, busy);
endinterface

// ==== src/pcie_rx.sv ====
module pcie_rx (
   input  logic                 clock,
   input  logic                 rst_n,
   input  logic                 tvalid,
   input  logic                 tlast,
   input  pcie_app_pkg::qword_t tdata,
   rx_req_if.parser             req
);

   pcie_app_pkg::rx_state_t state;
   logic [6:0]              fmt_type;
   logic                    two_dw;
   logic                    is_cpl;
   logic                    done;

   assign is_cpl = (fmt_type == pcie_app_pkg::cpld);

   // last beat of a TLP whose header has been taken
   assign done = tvalid && tlast && (state != pcie_app_pkg::rx_header);

   always_ff @(posedge clock)
   begin
      if (!rst_n)
      begin
         state <= pcie_app_pkg::rx_header;
      end
      else if (tvalid)
      begin
         case (state)
            pcie_app_pkg::rx_header:
            begin
               if (!tlast)
               begin
                  state <= pcie_app_pkg::rx_address;
               end
            end
            pcie_app_pkg::rx_address:
            begin
               if (tlast)
               begin
                  state <= pcie_app_pkg::rx_header;
               end
               else
               begin
                  state <= pcie_app_pkg::rx_payload;
               end
            end
            default:
            begin
               if (tlast)
               begin
                  state <= pcie_app_pkg::rx_header;
               end
            end
         endcase
      end
   end

   // strobes land one cycle after the tlast beat
   always_ff @(posedge clock)
   begin
      if (!rst_n)
      begin
         req.write_valid      <= 1'b0;
         req.read_valid       <= 1'b0;
         req.completion_valid <= 1'b0;
      end
      else
      begin
         req.write_valid      <= done && (fmt_type == pcie_app_pkg::mwr32);
         req.read_valid       <= done && (fmt_type == pcie_app_pkg::mrd32);
         req.completion_valid <= done && is_cpl;
      end
   end

   always_ff @(posedge clock)
   begin
      if (tvalid)
      begin
         case (state)
            pcie_app_pkg::rx_header:
            begin
               fmt_type    <= tdata[30:24];
               two_dw      <= (tdata[9:0] == 10'd2);
               // requester id and tag sit in DW1 bits 31 to 8
               req.rid_tag <= tdata[63:40];
            end
            pcie_app_pkg::rx_address:
            begin
               // completions carry no address in DW2
               if (!is_cpl)
               begin
                  req.address <= tdata[15:3];
               end
               req.data <= {32'h0, tdata[63:32]};
            end
            default:
            begin
               if (two_dw)
               begin
                  req.data[63:32] <= tdata[31:0];
               end
            end
         endcase
      end
   end

endmodule

// ==== src/app_regs.sv ====
module app_regs (
   input  logic               clock,
   input  logic               rst_n,
   input  logic               to_turnoff,
   rx_req_if.consumer         rx,
   tx_req_if.requester        tx,
   output logic               turnoff_ok,
   output pcie_app_pkg::led_t led
);

   pcie_app_pkg::qword_t      scratch;
   pcie_app_pkg::count_t      cpl_count;
   pcie_app_pkg::count_t      write_count;
   pcie_app_pkg::count_t      read_count;
   pcie_app_pkg::qword_t      read_data;
   pcie_app_pkg::rid_tag_t    read_rid_tag;
   pcie_app_pkg::lower_addr_t read_lower;
   logic                      read_done;
   logic                      pending;

   always_ff @(posedge clock)
   begin
      if (!rst_n)
      begin
         scratch     <= '0;
         cpl_count   <= '0;
         write_count <= '0;
         read_count  <= '0;
         led         <= pcie_app_pkg::led_reset;
      end
      else
      begin
         if (rx.write_valid)
         begin
            led         <= rx.data[3:0];
            write_count <= write_count + 16'd1;
            if (rx.address == pcie_app_pkg::reg_scratch)
            begin
               scratch <= rx.data;
            end
         end
         // inbound completion data lands in scratch
         if (rx.completion_valid)
         begin
            scratch   <= rx.data;
            cpl_count <= cpl_count + 16'd1;
         end
         if (rx.read_valid)
         begin
            read_count <= read_count + 16'd1;
         end
      end
   end

   always_ff @(posedge clock)
   begin
      if (rx.read_valid)
      begin
         read_rid_tag <= rx.rid_tag;
         read_lower   <= rx.address[3:0];
         case (rx.address)
            pcie_app_pkg::reg_scratch:     read_data <= scratch;
            pcie_app_pkg::reg_cpl_count:   read_data <= pcie_app_pkg::qword_t'(cpl_count);
            pcie_app_pkg::reg_write_count: read_data <= pcie_app_pkg::qword_t'(write_count);
            pcie_app_pkg::reg_read_count:  read_data <= pcie_app_pkg::qword_t'(read_count);
            default:
               read_data <= pcie_app_pkg::qword_t'({rx.address, pcie_app_pkg::bad_addr_marker});
         endcase
      end
   end

   // completion holding register, one deep
   always_ff @(posedge clock)
   begin
      if (!rst_n)
      begin
         read_done    <= 1'b0;
         tx.cpl_valid <= 1'b0;
      end
      else
      begin
         read_done <= rx.read_valid;
         if (read_done)
         begin
            tx.cpl_valid <= 1'b1;
         end
         else if (tx.cpl_ready)
         begin
            tx.cpl_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clock)
   begin
      if (read_done)
      begin
         tx.cpl_rid_tag    <= read_rid_tag;
         tx.cpl_lower_addr <= read_lower;
         tx.cpl_data       <= read_data;
      end
   end

   // doorbells
   always_ff @(posedge clock)
   begin
      if (!rst_n)
      begin
         tx.wr_valid <= 1'b0;
         tx.rd_valid <= 1'b0;
         tx.wr_data  <= pcie_app_pkg::write_seed;
      end
      else
      begin
         if (rx.write_valid && (rx.address == pcie_app_pkg::reg_dma_write))
         begin
            tx.wr_valid <= 1'b1;
         end
         else if (tx.wr_ready)
         begin
            tx.wr_valid <= 1'b0;
         end
         if (rx.write_valid && (rx.address == pcie_app_pkg::reg_dma_read))
         begin
            tx.rd_valid <= 1'b1;
         end
         else if (tx.rd_ready)
         begin
            tx.rd_valid <= 1'b0;
         end
         if (tx.wr_ready)
         begin
            tx.wr_data <= tx.wr_data + 64'd1;
         end
      end
   end

   always_ff @(posedge clock)
   begin
      if (rx.write_valid && (rx.address == pcie_app_pkg::reg_dma_write))
      begin
         tx.wr_addr <= rx.data;
      end
      if (rx.write_valid && (rx.address == pcie_app_pkg::reg_dma_read))
      begin
         tx.rd_addr <= rx.data;
      end
   end

   assign pending = tx.cpl_valid || tx.wr_valid || tx.rd_valid || tx.busy;

   // hold off the power-off ack while anything is outstanding
   always_ff @(posedge clock)
   begin
      if (!rst_n)
      begin
         turnoff_ok <= 1'b0;
      end
      else
      begin
         turnoff_ok <= to_turnoff && !pending;
      end
   end

endmodule

// ==== src/pcie_tx.sv ====
module pcie_tx (
   input  logic                   clock,
   input  logic                   rst_n,
   input  pcie_app_pkg::pcie_id_t pcie_id,
   tx_req_if.builder              req,
   input  logic                   tready,
   output logic                   tvalid,
   output logic                   tlast,
   output pcie_app_pkg::qword_t   tdata,
   output pcie_app_pkg::keep_t    tkeep
);

   pcie_app_pkg::tx_state_t  state;
   pcie_app_pkg::tx_state_t  last_state;
   pcie_app_pkg::tx_state_t  next_last;
   pcie_app_pkg::qword_t     beat1;
   pcie_app_pkg::qword_t     beat2;
   pcie_app_pkg::qword_t     beat3;
   pcie_app_pkg::qword_t     next_beat1;
   pcie_app_pkg::qword_t     next_beat2;
   pcie_app_pkg::qword_t     next_beat3;
   pcie_app_pkg::keep_t      last_keep;
   pcie_app_pkg::keep_t      next_keep;
   pcie_app_pkg::host_addr_t addr;
   logic [31:0]              lo_addr;
   logic                     hi_addr;
   logic [31:0]              dw0;
   logic [31:0]              dw1;
   logic [7:0]               tag;
   logic                     idle;
   logic                     start;

   assign idle  = (state == pcie_app_pkg::tx_idle);
   assign start = idle && (req.cpl_valid || req.wr_valid || req.rd_valid);

   // fixed priority: completion, write, read
   assign req.cpl_ready = idle && req.cpl_valid;
   assign req.wr_ready  = idle && !req.cpl_valid && req.wr_valid;
   assign req.rd_ready  = idle && !req.cpl_valid && !req.wr_valid && req.rd_valid;
   assign req.busy      = !idle;

   always_comb
   begin
      addr       = req.wr_valid ? req.wr_addr : req.rd_addr;
      lo_addr    = {addr[31:2], 2'b00};
      // a 4DW header only when the address needs it
      hi_addr    = |addr[63:32];
      dw1        = {pcie_id, tag, 8'hff};
      next_keep  = hi_addr ? 8'hff : 8'h0f;
      next_beat3 = '0;
      if (req.cpl_valid)
      begin
         dw0        = {1'b0, pcie_app_pkg::cpld, 14'd0, 10'd2};
         // completer id, successful status, byte count 8
         dw1        = {pcie_id, 3'b000, 1'b0, 12'd8};
         next_beat2 = {req.cpl_data[31:0], req.cpl_rid_tag, 1'b0, req.cpl_lower_addr, 3'b000};
         next_beat3 = {32'h0, req.cpl_data[63:32]};
         next_keep  = 8'h0f;
         next_last  = pcie_app_pkg::tx_beat3;
      end
      else if (req.wr_valid)
      begin
         dw0 = {1'b0, hi_addr ? pcie_app_pkg::mwr64 : pcie_app_pkg::mwr32, 14'd0, 10'd2};
         if (hi_addr)
         begin
            next_beat2 = {lo_addr, addr[63:32]};
            next_beat3 = req.wr_data;
         end
         else
         begin
            next_beat2 = {req.wr_data[31:0], lo_addr};
            next_beat3 = {32'h0, req.wr_data[63:32]};
         end
         next_last = pcie_app_pkg::tx_beat3;
      end
      else
      begin
         dw0 = {1'b0, hi_addr ? pcie_app_pkg::mrd64 : pcie_app_pkg::mrd32, 14'd0, 10'd2};
         if (hi_addr)
         begin
            next_beat2 = {lo_addr, addr[63:32]};
         end
         else
         begin
            next_beat2 = {32'h0, lo_addr};
         end
         next_last = pcie_app_pkg::tx_beat2;
      end
      next_beat1 = {dw1, dw0};
   end

   always_ff @(posedge clock)
   begin
      if (!rst_n)
      begin
         state      <= pcie_app_pkg::tx_idle;
         last_state <= pcie_app_pkg::tx_beat3;
         tag        <= '0;
      end
      else
      begin
         case (state)
            pcie_app_pkg::tx_idle:
            begin
               if (start)
               begin
                  state      <= pcie_app_pkg::tx_beat1;
                  last_state <= next_last;
               end
            end
            pcie_app_pkg::tx_beat1:
            begin
               if (tready)
               begin
                  state <= pcie_app_pkg::tx_beat2;
               end
            end
            pcie_app_pkg::tx_beat2:
            begin
               if (tready)
               begin
                  state <= tlast ? pcie_app_pkg::tx_idle : pcie_app_pkg::tx_beat3;
               end
            end
            default:
            begin
               if (tready)
               begin
                  state <= pcie_app_pkg::tx_idle;
               end
            end
         endcase
         // tags only matter for reads
         if (req.rd_ready)
         begin
            tag <= tag + 8'd1;
         end
      end
   end

   always_ff @(posedge clock)
   begin
      if (start)
      begin
         beat1     <= next_beat1;
         beat2     <= next_beat2;
         beat3     <= next_beat3;
         last_keep <= next_keep;
      end
   end

   assign tvalid = !idle;
   assign tlast  = tvalid && (state == last_state);
   assign tkeep  = tlast ? last_keep : 8'hff;

   always_comb
   begin
      case (state)
         pcie_app_pkg::tx_beat1: tdata = beat1;
         pcie_app_pkg::tx_beat2: tdata = beat2;
         pcie_app_pkg::tx_beat3: tdata = beat3;
         default:                tdata = '0;
      endcase
   end

endmodule

// ==== src/pcie_app_top.sv ====
module pcie_app_top (
   input  logic                   clock,
   input  logic                   rst_n,
   input  logic                   link_up,
   input  logic                   rx_tvalid,
   input  logic                   rx_tlast,
   input  pcie_app_pkg::qword_t   rx_tdata,
   input  logic                   tx_tready,
   output logic                   tx_tvalid,
   output logic                   tx_tlast,
   output pcie_app_pkg::qword_t   tx_tdata,
   output pcie_app_pkg::keep_t    tx_tkeep,
   input  pcie_app_pkg::pcie_id_t pcie_id,
   input  logic                   to_turnoff,
   output logic                   turnoff_ok,
   output pcie_app_pkg::led_t     led
);

   logic app_rst_n;

   rx_req_if rx_req ();
   tx_req_if tx_req ();

   // held in reset while the link is down
   always_ff @(posedge clock)
   begin
      app_rst_n <= rst_n && link_up;
   end

   pcie_rx pcie_rx_i (
      .clock  (clock),
      .rst_n  (app_rst_n),
      .tvalid (rx_tvalid),
      .tlast  (rx_tlast),
      .tdata  (rx_tdata),
      .req    (rx_req.parser)
   );

   app_regs app_regs_i (
      .clock      (clock),
      .rst_n      (app_rst_n),
      .to_turnoff (to_turnoff),
      .rx         (rx_req.consumer),
      .tx         (tx_req.requester),
      .turnoff_ok (turnoff_ok),
      .led        (led)
   );

   pcie_tx pcie_tx_i (
      .clock   (clock),
      .rst_n   (app_rst_n),
      .pcie_id (pcie_id),
      .req     (tx_req.builder),
      .tready  (tx_tready),
      .tvalid  (tx_tvalid),
      .tlast   (tx_tlast),
      .tdata   (tx_tdata),
      .tkeep   (tx_tkeep)
   );

endmodule

// ==== dv/pcie_app_assert.sv ====
module pcie_app_assert (
   input logic                 clock,
   input logic                 rst_n,
   input logic                 tvalid,
   input logic                 tready,
   input logic                 tlast,
   input pcie_app_pkg::qword_t tdata,
   input pcie_app_pkg::keep_t  tkeep
);
   timeunit 1ns;
   timeprecision 1ps;

   // count of failed assertions
   int failures = 0;

   // builder idle one edge after reset is seen
   reset_idle: assert property (@(posedge clock) !rst_n |=> !tvalid)
      else
      begin
         $error("tvalid not low after a reset cycle");
         failures++;
      end

   // a stalled beat holds until it transfers
   stall_hold: assert property (@(posedge clock) disable iff (!rst_n)
      tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tkeep) && $stable(tlast))
      else
      begin
         $error("transmit beat changed while stalled");
         failures++;
      end

   // beats of one TLP follow each other without a gap
   no_gap: assert property (@(posedge clock) disable iff (!rst_n)
      tvalid && tready && !tlast |=> tvalid)
      else
      begin
         $error("tvalid dropped inside a TLP");
         failures++;
      end

endmodule

// ==== dv/tb_pcie_app.sv ====
module tb_pcie_app;
   timeunit 1ns;
   timeprecision 1ps;

   localparam pcie_app_pkg::pcie_id_t my_id         = 16'h0108;
   localparam pcie_app_pkg::qword_t   scratch_value = 64'h0123_4567_89ab_cdea;
   localparam pcie_app_pkg::qword_t   cpl_value     = 64'hfeed_0000_cafe_0001;
   localparam int                     max_wait      = 300;

   logic                   clock = 1'b0;
   logic                   rst_n;
   logic                   link_up;
   logic                   rx_tvalid;
   logic                   rx_tlast;
   pcie_app_pkg::qword_t   rx_tdata;
   logic                   tx_tready;
   logic                   tx_tvalid;
   logic                   tx_tlast;
   pcie_app_pkg::qword_t   tx_tdata;
   pcie_app_pkg::keep_t    tx_tkeep;
   pcie_app_pkg::pcie_id_t pcie_id;
   logic                   to_turnoff;
   logic                   turnoff_ok;
   pcie_app_pkg::led_t     led;

   // expected state kept alongside the DUT
   pcie_app_pkg::count_t   writes_sent;
   pcie_app_pkg::count_t   reads_sent;
   pcie_app_pkg::count_t   cpls_sent;
   logic [7:0]             next_tag;
   pcie_app_pkg::qword_t   beats[$];
   pcie_app_pkg::keep_t    last_keep;
   logic                   random_ready;
   int                     seed;
   int                     errors;
   int                     timeouts;

   pcie_app_top dut_i (.*);

   bind pcie_tx pcie_app_assert assert_i (.*);

   always #4 clock = ~clock;

   task automatic report_mismatch(input string what, input logic [63:0] got, exp);
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
   endtask

   task automatic check_qword(input pcie_app_pkg::qword_t got, exp, input string what);
      if (got !== exp)
         report_mismatch(what, got, exp);
   endtask

   task automatic check_keep(input pcie_app_pkg::keep_t got, exp, input string what);
      if (got !== exp)
         report_mismatch(what, got, exp);
   endtask

   task automatic check_count(input pcie_app_pkg::count_t got, exp, input string what);
      if (got !== exp)
         report_mismatch(what, got, exp);
   endtask

   task automatic check_led(input pcie_app_pkg::led_t got, exp, input string what);
      if (got !== exp)
         report_mismatch(what, got, exp);
   endtask

   task automatic check_bit(input logic got, exp, input string what);
      if (got !== exp)
         report_mismatch(what, got, exp);
   endtask

   task automatic send_tlp(input pcie_app_pkg::qword_t b0, b1, b2, input int n);
      pcie_app_pkg::qword_t tlp[3];
      tlp[0] = b0;
      tlp[1] = b1;
      tlp[2] = b2;
      for (int i = 0; i < n; i++)
      begin
         @(posedge clock);
         rx_tvalid <= 1'b1;
         rx_tlast  <= (i == n - 1);
         rx_tdata  <= tlp[i];
      end
      @(posedge clock);
      rx_tvalid <= 1'b0;
      rx_tlast  <= 1'b0;
   endtask

   // 3DW memory write of two dwords from requester 0
   task automatic write_reg(input pcie_app_pkg::qword_addr_t qaddr,
                            input pcie_app_pkg::qword_t data);
      send_tlp({32'h0000_00ff, 1'b0, pcie_app_pkg::mwr32, 14'd0, 10'd2},
               {data[31:0], 16'h0, qaddr, 3'b000}, {32'h0, data[63:32]}, 3);
      writes_sent++;
      repeat (2) @(posedge clock);
   endtask

   task automatic send_read(input pcie_app_pkg::qword_addr_t qaddr,
                            input pcie_app_pkg::rid_tag_t rid_tag);
      send_tlp({rid_tag, 8'hff, 1'b0, pcie_app_pkg::mrd32, 14'd0, 10'd2},
               {32'h0, 16'h0, qaddr, 3'b000}, '0, 2);
      reads_sent++;
   endtask

   task automatic send_completion(input pcie_app_pkg::qword_t data);
      send_tlp({32'h0000_0008, 1'b0, pcie_app_pkg::cpld, 14'd0, 10'd2},
               {data[31:0], my_id, 16'h0000}, {32'h0, data[63:32]}, 3);
      cpls_sent++;
      repeat (2) @(posedge clock);
   endtask

   // tready goes low again once the tlast beat has transferred
   task automatic collect_tlp();
      int   waited;
      int   coin;
      logic done;
      beats.delete();
      waited = 0;
      done   = 1'b0;
      while (!done && waited < max_wait)
      begin
         coin = $random(seed);
         @(posedge clock);
         tx_tready <= !random_ready || coin[0];
         @(negedge clock);
         waited++;
         if (to_turnoff)
            check_bit(turnoff_ok, 1'b0, "turnoff_ok before the completion ends");
         if (tx_tvalid && tx_tready)
         begin
            beats.push_back(tx_tdata);
            last_keep = tx_tkeep;
            done      = tx_tlast;
         end
      end
      @(posedge clock);
      tx_tready <= 1'b0;
      if (!done)
      begin
         $display("timeout: no complete TLP left the transmit stream by %0t ns", $time);
         timeouts++;
      end
   endtask

   task automatic wait_for_high(input logic turnoff, input string what);
      int   waited;
      logic seen;
      waited = 0;
      seen   = 1'b0;
      while (!seen && waited < max_wait)
      begin
         @(negedge clock);
         waited++;
         seen = turnoff ? turnoff_ok : tx_tvalid;
      end
      if (!seen)
      begin
         $display("timeout: %s never went high, gave up at %0t ns", what, $time);
         timeouts++;
      end
   endtask

   task automatic check_completion(input pcie_app_pkg::qword_addr_t qaddr,
                                   input pcie_app_pkg::rid_tag_t rid_tag,
                                   output pcie_app_pkg::qword_t data);
      if (beats.size() != 3)
         report_mismatch("beats in completion", beats.size(), 3);
      check_qword(beats[0], {my_id, 16'h0008, 1'b0, pcie_app_pkg::cpld, 14'd0, 10'd2},
                  "completion header");
      check_qword({32'h0, beats[1][31:0]}, {32'h0, rid_tag, 1'b0, qaddr[3:0], 3'b000},
                  "completion requester and lower address");
      check_keep(last_keep, 8'h0f, "completion last keep");
      data = {beats[2][31:0], beats[1][63:32]};
   endtask

   task automatic read_reg(input pcie_app_pkg::qword_addr_t qaddr,
                           input pcie_app_pkg::rid_tag_t rid_tag,
                           output pcie_app_pkg::qword_t data);
      send_read(qaddr, rid_tag);
      collect_tlp();
      check_completion(qaddr, rid_tag, data);
   endtask

   // 4DW header whenever the upper address half is in use
   task automatic expect_request(input logic [6:0] fmt, input pcie_app_pkg::host_addr_t addr,
                                 input pcie_app_pkg::qword_t data);
      logic wide;
      logic is_read;
      wide    = (addr[63:32] != 32'h0);
      is_read = (fmt == pcie_app_pkg::mrd32) || (fmt == pcie_app_pkg::mrd64);
      collect_tlp();
      if (beats.size() != (is_read ? 2 : 3))
         report_mismatch("beats in request", beats.size(), is_read ? 2 : 3);
      check_qword(beats[0], {my_id, next_tag, 8'hff, 1'b0, fmt, 14'd0, 10'd2},
                  "request header");
      if (wide)
         check_qword(beats[1], {addr[31:0], addr[63:32]}, "64-bit request address");
      else
         check_qword(beats[1], {is_read ? 32'h0 : data[31:0], addr[31:0]},
                     "32-bit request address");
      if (!is_read)
         check_qword(beats[2], wide ? data : {32'h0, data[63:32]}, "request data");
      check_keep(last_keep, wide ? 8'hff : 8'h0f, "request last keep");
      if (is_read)
         next_tag++;
   endtask

   task automatic test_reset_state();
      repeat (2) @(posedge clock);
      @(negedge clock);
      check_bit(tx_tvalid, 1'b0, "tx_tvalid after reset");
      check_bit(turnoff_ok, 1'b0, "turnoff_ok after reset");
      check_led(led, 4'h5, "led after reset");
   endtask

   task automatic test_scratch();
      pcie_app_pkg::qword_t data;
      write_reg(pcie_app_pkg::reg_scratch, scratch_value);
      @(negedge clock);
      check_led(led, scratch_value[3:0], "led after scratch write");
      read_reg(pcie_app_pkg::reg_scratch, 24'h020015, data);
      check_qword(data, scratch_value, "scratch readback");
   endtask

   task automatic test_counters();
      pcie_app_pkg::qword_t data;
      pcie_app_pkg::count_t reads_before;
      for (int i = 0; i < 3; i++)
         write_reg(13'd7, 64'(i));
      read_reg(pcie_app_pkg::reg_write_count, 24'h020021, data);
      check_count(data[15:0], writes_sent, "write counter");
      reads_before = reads_sent;
      read_reg(pcie_app_pkg::reg_read_count, 24'h020022, data);
      check_count(data[15:0], reads_before, "read counter");
      read_reg(13'd5, 24'h020023, data);
      check_qword(data, {32'd5, pcie_app_pkg::bad_addr_marker}, "unmapped read");
   endtask

   task automatic test_write_doorbell();
      write_reg(pcie_app_pkg::reg_dma_write, 64'h0000_0000_8000_1000);
      expect_request(pcie_app_pkg::mwr32, 64'h0000_0000_8000_1000, 64'h100);
      write_reg(pcie_app_pkg::reg_dma_write, 64'h0000_0012_3456_7000);
      expect_request(pcie_app_pkg::mwr64, 64'h0000_0012_3456_7000, 64'h101);
   endtask

   task automatic test_read_doorbell();
      pcie_app_pkg::qword_t data;
      write_reg(pcie_app_pkg::reg_dma_read, 64'h0000_0000_0004_0000);
      expect_request(pcie_app_pkg::mrd32, 64'h0000_0000_0004_0000, '0);
      write_reg(pcie_app_pkg::reg_dma_read, 64'h0000_0001_0000_0000);
      expect_request(pcie_app_pkg::mrd64, 64'h0000_0001_0000_0000, '0);
      send_completion(cpl_value);
      read_reg(pcie_app_pkg::reg_scratch, 24'h020031, data);
      check_qword(data, cpl_value, "scratch after inbound completion");
      read_reg(pcie_app_pkg::reg_cpl_count, 24'h020032, data);
      check_count(data[15:0], cpls_sent, "completion counter");
   endtask

   task automatic test_backpressure();
      pcie_app_pkg::qword_t data;
      write_reg(pcie_app_pkg::reg_scratch, scratch_value);
      random_ready = 1'b1;
      for (int i = 0; i < 6; i++)
      begin
         read_reg(pcie_app_pkg::reg_scratch, 24'h030000 + 24'(i), data);
         check_qword(data, scratch_value, "scratch read under back-pressure");
      end
      random_ready = 1'b0;
      // completion parked behind a stalled stream
      send_read(pcie_app_pkg::reg_scratch, 24'h030077);
      wait_for_high(1'b0, "tx_tvalid");
      @(posedge clock);
      to_turnoff <= 1'b1;
      repeat (4) @(posedge clock);
      collect_tlp();
      check_completion(pcie_app_pkg::reg_scratch, 24'h030077, data);
      check_qword(data, scratch_value, "stalled completion data");
      wait_for_high(1'b1, "turnoff_ok");
      @(posedge clock);
      to_turnoff <= 1'b0;
   endtask

   initial
   begin
      seed         = 35749;
      errors       = 0;
      timeouts     = 0;
      writes_sent  = '0;
      reads_sent   = '0;
      cpls_sent    = '0;
      next_tag     = '0;
      random_ready = 1'b0;
      rst_n        = 1'b0;
      link_up      = 1'b1;
      rx_tvalid    = 1'b0;
      rx_tlast     = 1'b0;
      rx_tdata     = '0;
      tx_tready    = 1'b0;
      pcie_id      = my_id;
      to_turnoff   = 1'b0;
      repeat (3) @(posedge clock);
      rst_n <= 1'b1;
      test_reset_state();
      test_scratch();
      test_counters();
      test_write_doorbell();
      test_read_doorbell();
      test_backpressure();
      $display("checks finished with %0d errors, %0d timeouts and %0d assertion failures",
               errors, timeouts, dut_i.pcie_tx_i.assert_i.failures);
      if (errors == 0 && timeouts == 0 && dut_i.pcie_tx_i.assert_i.failures == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// ==== all.f ====
src/pcie_app_pkg.sv
src/pcie_app_if.sv
src/pcie_rx.sv
src/app_regs.sv
src/pcie_tx.sv
src/pcie_app_top.sv
dv/pcie_app_assert.sv
dv/tb_pcie_app.sv

// ==== Bender.yml ====
package:
  name: pcie_app

sources:
  - files:
      - src/pcie_app_pkg.sv
      - src/pcie_app_if.sv
      - src/pcie_rx.sv
      - src/app_regs.sv
      - src/pcie_tx.sv
      - src/pcie_app_top.sv
  - target: simulation
    files:
      - dv/pcie_app_assert.sv
      - dv/tb_pcie_app.sv
